//--- code8b10b_pkg.sv
package code8b10b_pkg;

	// Width of one data byte
	localparam int BYTE_W = 8;

	// Input symbol is the K flag on top of the byte
	localparam int SYM_IN_W = BYTE_W + 1;

	// Width of one 8b/10b code group
	localparam int CODE_W = 10;

	// Input symbol
	// bit 8 set marks a control symbol, bits 7:0 carry the byte
	typedef logic [SYM_IN_W-1:0] in_sym_t;

	// Code group as it leaves the encoder
	// bit 0 is transmitted first (a), bit 9 last (j)
	// bits 5:0 hold abcdei and bits 9:6 hold fghj
	typedef logic [CODE_W-1:0] code_t;

	// Comma used for the packet preamble
	localparam in_sym_t K28_1 = 9'h13C;

	// End-of-body marker, echoed ahead of the CRC trailer
	localparam in_sym_t K23_7 = 9'h1F7;

	// Closing comma after the trailer
	localparam in_sym_t K28_5 = 9'h1BC;

endpackage

//--- frame_pkg.sv
package frame_pkg;

	// Packet framer states
	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		BODY,
		TRAILER,
		CLOSE
	} frame_state_t;

	// CRC-32 width
	localparam int CRC_W = 32;

	// Reflected form of 04C11DB7, bytes fed LSB first
	localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB8_8320;

	// Seed loaded at the start of each packet
	localparam logic [CRC_W-1:0] CRC_INIT = 32'hFFFF_FFFF;

	// Final inversion on the way out
	localparam logic [CRC_W-1:0] CRC_XOR_OUT = 32'hFFFF_FFFF;

endpackage

//--- encoder_8b10b.sv
`timescale 1ns/100ps

module encoder_8b10b (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   push,
	input  logic                   start,
	input  code8b10b_pkg::in_sym_t sym,
	output logic                   pushout,
	output logic                   startout,
	output code8b10b_pkg::code_t   dataout
);

	// Running disparity is 1 when positive
	logic rd_pos;
	// Disparity between the 6b and 4b sub-blocks
	logic rd6_pos;
	logic alt7;
	logic [5:0] d6;
	logic [3:0] d4;
	code8b10b_pkg::code_t code;

	// 5b/6b table in its RD- column
	function automatic logic [5:0] enc_5b6b(input logic [4:0] x);
		case (x)
			5'd0:  return 6'b111001;
			5'd1:  return 6'b101110;
			5'd2:  return 6'b101101;
			5'd3:  return 6'b100011;
			5'd4:  return 6'b101011;
			5'd5:  return 6'b100101;
			5'd6:  return 6'b100110;
			5'd7:  return 6'b000111;
			5'd8:  return 6'b100111;
			5'd9:  return 6'b101001;
			5'd10: return 6'b101010;
			5'd11: return 6'b001011;
			5'd12: return 6'b101100;
			5'd13: return 6'b001101;
			5'd14: return 6'b001110;
			5'd15: return 6'b111010;
			5'd16: return 6'b110110;
			5'd17: return 6'b110001;
			5'd18: return 6'b110010;
			5'd19: return 6'b010011;
			5'd20: return 6'b110100;
			5'd21: return 6'b010101;
			5'd22: return 6'b010110;
			5'd23: return 6'b010111;
			5'd24: return 6'b110011;
			5'd25: return 6'b011001;
			5'd26: return 6'b011010;
			5'd27: return 6'b011011;
			5'd28: return 6'b011100;
			5'd29: return 6'b011101;
			5'd30: return 6'b011110;
			default: return 6'b110101;
		endcase
	endfunction

	// 3b/4b table in its RD- column where alt picks D.x.A7
	function automatic logic [3:0] enc_3b4b(input logic [2:0] y, input logic alt);
		case (y)
			3'd0: return 4'b1101;
			3'd1: return 4'b1001;
			3'd2: return 4'b1010;
			3'd3: return 4'b0011;
			3'd4: return 4'b1011;
			3'd5: return 4'b0101;
			3'd6: return 4'b0110;
			default: return alt ? 4'b1110 : 4'b0111;
		endcase
	endfunction

	// Kept control symbols in their RD- form
	function automatic code8b10b_pkg::code_t enc_k(input code8b10b_pkg::in_sym_t k);
		case (k)
			code8b10b_pkg::K28_1: return 10'b1001111100;
			code8b10b_pkg::K23_7: return 10'b0001010111;
			code8b10b_pkg::K28_5: return 10'b0101111100;
			default: return '0;
		endcase
	endfunction

	always_comb begin
		d6 = enc_5b6b(sym[4:0]);
		// Unbalanced groups and D.7 flip for RD+
		if (rd_pos && ($countones(d6) != 3 || sym[4:0] == 5'd7))
			d6 = ~d6;
		rd6_pos = rd_pos ^ ($countones(d6) != 3);
		// A7 avoids a run of five equal bits across the boundary
		alt7 = rd6_pos ? (sym[4:0] inside {5'd11, 5'd13, 5'd14}) :
			(sym[4:0] inside {5'd17, 5'd18, 5'd20});
		d4 = enc_3b4b(sym[7:5], alt7);
		if (rd6_pos && ($countones(d4) != 2 || sym[7:5] == 3'd3))
			d4 = ~d4;
		if (sym[8])
			code = rd_pos ? ~enc_k(sym) : enc_k(sym);
		else
			code = {d4, d6};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
			startout <= 1'b0;
			dataout <= '0;
			rd_pos <= 1'b0;
		end else begin
			pushout <= push;
			startout <= start;
			if (push) begin
				dataout <= code;
				// K28.5 ends a packet and the line restarts at RD-
				if (sym == code8b10b_pkg::K28_5)
					rd_pos <= 1'b0;
				else
					rd_pos <= rd_pos ^ ($countones(code) != 5);
			end
		end
	end

	a_code_weight: assert property (@(posedge clk) disable iff (reset)
		pushout |-> $countones(dataout) inside {[4:6]});

	a_start_with_push: assert property (@(posedge clk) disable iff (reset)
		$rose(startout) |-> pushout);

endmodule

//--- crc32_accumulator.sv
`timescale 1ns/100ps

module crc32_accumulator (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             clear,
	input  logic                             update,
	input  logic [code8b10b_pkg::BYTE_W-1:0] data,
	output logic [frame_pkg::CRC_W-1:0]      crc
);

	logic [frame_pkg::CRC_W-1:0] state;

	// One byte through the shift register, LSB first
	function automatic logic [frame_pkg::CRC_W-1:0] fold_byte(
		input logic [frame_pkg::CRC_W-1:0] c,
		input logic [code8b10b_pkg::BYTE_W-1:0] d
	);
		logic [frame_pkg::CRC_W-1:0] r;
		r = c;
		for (int i = 0; i < code8b10b_pkg::BYTE_W; i++)
			r = (r[0] ^ d[i]) ? ((r >> 1) ^ frame_pkg::CRC_POLY) : (r >> 1);
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (reset || clear)
			state <= frame_pkg::CRC_INIT;
		else if (update)
			state <= fold_byte(state, data);
	end

	assign crc = state ^ frame_pkg::CRC_XOR_OUT;

	a_clear_update: assert property (@(posedge clk) disable iff (reset)
		!(clear && update));

endmodule

//--- packet_framer.sv
`timescale 1ns/100ps

module packet_framer #(
	parameter int PREAMBLE_LEN = 4
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             pushin,
	input  logic                             startin,
	input  code8b10b_pkg::in_sym_t           datain,
	input  logic [frame_pkg::CRC_W-1:0]      crc_value,
	output logic                             enc_push,
	output logic                             enc_start,
	output code8b10b_pkg::in_sym_t           enc_sym,
	output logic                             crc_clear,
	output logic                             crc_update,
	output logic [code8b10b_pkg::BYTE_W-1:0] crc_byte
);

	localparam int CNT_W = $clog2(PREAMBLE_LEN + 1);

	frame_pkg::frame_state_t state;
	frame_pkg::frame_state_t state_next;
	// Preamble symbols accepted so far
	logic [CNT_W-1:0] pre_cnt;
	logic [CNT_W-1:0] pre_next;
	// CRC byte index counting up from the low byte
	logic [1:0] trail_cnt;
	logic [1:0] trail_next;

	assign crc_byte = datain[code8b10b_pkg::BYTE_W-1:0];

	always_comb begin
		state_next = state;
		pre_next = pre_cnt;
		trail_next = trail_cnt;
		enc_push = 1'b0;
		enc_start = 1'b0;
		enc_sym = datain;
		crc_clear = 1'b0;
		crc_update = 1'b0;
		case (state)
			frame_pkg::IDLE: begin
				if (pushin && startin && datain == code8b10b_pkg::K28_1) begin
					enc_push = 1'b1;
					enc_start = 1'b1;
					crc_clear = 1'b1;
					pre_next = CNT_W'(1);
					state_next = (PREAMBLE_LEN > 1) ? frame_pkg::PREAMBLE : frame_pkg::BODY;
				end
			end
			frame_pkg::PREAMBLE: begin
				if (pushin) begin
					if (datain == code8b10b_pkg::K28_1) begin
						enc_push = 1'b1;
						pre_next = pre_cnt + 1'b1;
						if (pre_cnt == CNT_W'(PREAMBLE_LEN - 1))
							state_next = frame_pkg::BODY;
					end else begin
						// Broken preamble drops the packet
						state_next = frame_pkg::IDLE;
					end
				end
			end
			frame_pkg::BODY: begin
				if (pushin) begin
					if (!datain[8]) begin
						enc_push = 1'b1;
						crc_update = 1'b1;
					end else if (datain == code8b10b_pkg::K23_7) begin
						enc_push = 1'b1;
						trail_next = 2'd0;
						state_next = frame_pkg::TRAILER;
					end
				end
			end
			frame_pkg::TRAILER: begin
				// Input is ignored until the trailer is out
				enc_push = 1'b1;
				enc_sym = {1'b0, crc_value[{trail_cnt, 3'b000} +: code8b10b_pkg::BYTE_W]};
				trail_next = trail_cnt + 1'b1;
				if (trail_cnt == 2'd3)
					state_next = frame_pkg::CLOSE;
			end
			frame_pkg::CLOSE: begin
				enc_push = 1'b1;
				enc_sym = code8b10b_pkg::K28_5;
				state_next = frame_pkg::IDLE;
			end
			default: state_next = frame_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= frame_pkg::IDLE;
			pre_cnt <= '0;
			trail_cnt <= '0;
		end else begin
			state <= state_next;
			pre_cnt <= pre_next;
			trail_cnt <= trail_next;
		end
	end

	// Preamble count stays inside the opening
	a_pre_cnt_range: assert property (@(posedge clk) disable iff (reset)
		state == frame_pkg::PREAMBLE |-> pre_cnt != '0 && pre_cnt < CNT_W'(PREAMBLE_LEN));

endmodule

//--- line_encoder_top.sv
`timescale 1ns/100ps

module line_encoder_top #(
	parameter int PREAMBLE_LEN = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pushin,
	input  logic                   startin,
	input  code8b10b_pkg::in_sym_t datain,
	output logic                   pushout,
	output logic                   startout,
	output code8b10b_pkg::code_t   dataout
);

	logic enc_push;
	logic enc_start;
	code8b10b_pkg::in_sym_t enc_sym;
	logic crc_clear;
	logic crc_update;
	logic [code8b10b_pkg::BYTE_W-1:0] crc_byte;
	logic [frame_pkg::CRC_W-1:0] crc_value;

	// Symbol selection and packet sequencing
	packet_framer #(
		.PREAMBLE_LEN(PREAMBLE_LEN)
	) packet_framer_i (
		.clk       (clk),
		.reset     (reset),
		.pushin    (pushin),
		.startin   (startin),
		.datain    (datain),
		.crc_value (crc_value),
		.enc_push  (enc_push),
		.enc_start (enc_start),
		.enc_sym   (enc_sym),
		.crc_clear (crc_clear),
		.crc_update(crc_update),
		.crc_byte  (crc_byte)
	);

	crc32_accumulator crc32_accumulator_i (
		.clk   (clk),
		.reset (reset),
		.clear (crc_clear),
		.update(crc_update),
		.data  (crc_byte),
		.crc   (crc_value)
	);

	// One cycle from framer selection to line output
	encoder_8b10b encoder_8b10b_i (
		.clk     (clk),
		.reset   (reset),
		.push    (enc_push),
		.start   (enc_start),
		.sym     (enc_sym),
		.pushout (pushout),
		.startout(startout),
		.dataout (dataout)
	);

endmodule

//--- tb_encode_model.svh
`ifndef TB_ENCODE_MODEL_SVH
`define TB_ENCODE_MODEL_SVH

// Model running disparity, -1 or +1
int model_rd;

// 5b/6b RD- column, written abcdei with a as the MSB
localparam logic [5:0] SIX_B [32] = '{
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b RD- column as fghj, last entry is D.x.P7
localparam logic [3:0] FOUR_B [8] = '{
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

// Table order has a first, the line word has a in bit 0
function automatic code8b10b_pkg::code_t reverse10(input logic [9:0] v);
	code8b10b_pkg::code_t r;
	for (int i = 0; i < 10; i++)
		r[i] = v[9 - i];
	return r;
endfunction

function automatic logic is_k28_5(input code8b10b_pkg::code_t c);
	return c == reverse10(10'b0011111010) || c == ~reverse10(10'b0011111010);
endfunction

// Encodes one symbol and moves the model disparity on
task automatic encode_sym(input code8b10b_pkg::in_sym_t s, output code8b10b_pkg::code_t c);
	logic [5:0] six;
	logic [3:0] four;
	logic [9:0] k;
	if (s[8]) begin
		case (s)
			code8b10b_pkg::K28_1: k = 10'b0011111001;
			code8b10b_pkg::K23_7: k = 10'b1110101000;
			default: k = 10'b0011111010;
		endcase
		if (model_rd > 0)
			k = ~k;
		c = reverse10(k);
		if ($countones(k) != 5)
			model_rd = -model_rd;
		if (s == code8b10b_pkg::K28_5)
			model_rd = -1;
	end else begin
		six = SIX_B[s[4:0]];
		if (model_rd > 0 && ($countones(six) != 3 || s[4:0] == 5'd7))
			six = ~six;
		if ($countones(six) != 3)
			model_rd = -model_rd;
		four = FOUR_B[s[7:5]];
		// D.x.A7 where P7 would extend a run across the sub-blocks
		if (s[7:5] == 3'd7 && ((model_rd < 0 && s[4:0] inside {5'd17, 5'd18, 5'd20}) ||
				(model_rd > 0 && s[4:0] inside {5'd11, 5'd13, 5'd14})))
			four = 4'b0111;
		if (model_rd > 0 && ($countones(four) != 2 || s[7:5] == 3'd3))
			four = ~four;
		if ($countones(four) != 2)
			model_rd = -model_rd;
		c = reverse10({six, four});
	end
endtask

// Bitwise reflected CRC-32, one byte
function automatic logic [31:0] crc_fold(input logic [31:0] c, input logic [7:0] d);
	logic [31:0] r;
	r = c ^ {24'd0, d};
	for (int i = 0; i < 8; i++)
		r = r[0] ? ((r >> 1) ^ frame_pkg::CRC_POLY) : (r >> 1);
	return r;
endfunction

`endif

//--- line_encoder_tb.sv
`timescale 1ns/100ps

module line_encoder_tb;

	localparam int PREAMBLE_LEN = 4;
	localparam int N_PACKETS = 40;
	localparam int TIMEOUT_CYCLES = N_PACKETS * 40 + 200;

	// Control symbols the body drops
	localparam code8b10b_pkg::in_sym_t IGNORED_K [9] = '{
		9'h11C, 9'h15C, 9'h17C, 9'h19C, 9'h1DC, 9'h1FC, 9'h1FB, 9'h1FD, 9'h1FE
	};

	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	code8b10b_pkg::in_sym_t datain;
	logic pushout;
	logic startout;
	code8b10b_pkg::code_t dataout;

	// Expected {pushout, startout, dataout} per cycle
	logic [11:0] exp_q[$];
	frame_pkg::frame_state_t m_state;
	int pre_seen;
	int trail_idx;
	logic [31:0] model_crc;
	// Disparity as seen on the line
	int line_rd;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	`include "tb_encode_model.svh"

	line_encoder_top #(
		.PREAMBLE_LEN(PREAMBLE_LEN)
	) line_encoder_top_i (
		.clk     (clk),
		.reset   (reset),
		.pushin  (pushin),
		.startin (startin),
		.datain  (datain),
		.pushout (pushout),
		.startout(startout),
		.dataout (dataout)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles, %0d errors so far", cycle_count, errors);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	function automatic logic one_in(input int n);
		return $urandom_range(n - 1, 0) == 0;
	endfunction

	task automatic emit(input code8b10b_pkg::in_sym_t sym, input logic st, output logic [11:0] e);
		code8b10b_pkg::code_t c;
		encode_sym(sym, c);
		e = {1'b1, st, c};
	endtask

	// Checks last cycle's output, then drives and predicts the next
	task automatic step(input logic p, input logic s, input code8b10b_pkg::in_sym_t d);
		logic [11:0] e;
		int weight;
		@(negedge clk);
		e = exp_q.pop_front();
		check_value("pushout", pushout, e[11]);
		check_value("startout", startout, e[10]);
		if (e[11]) begin
			check_value("dataout", dataout, e[9:0]);
			weight = $countones(dataout);
			check_value("code weight 4 to 6", weight >= 4 && weight <= 6, 1);
			// Ones minus zeros of the code group
			line_rd = line_rd + 2 * weight - 10;
			check_value("line disparity within 1", line_rd == 1 || line_rd == -1, 1);
			if (is_k28_5(dataout))
				line_rd = -1;
		end
		pushin = p;
		startin = s;
		datain = d;
		e = '0;
		case (m_state)
			frame_pkg::IDLE:
				if (p && s && d == code8b10b_pkg::K28_1) begin
					emit(d, 1'b1, e);
					model_crc = frame_pkg::CRC_INIT;
					pre_seen = 1;
					m_state = (pre_seen == PREAMBLE_LEN) ? frame_pkg::BODY : frame_pkg::PREAMBLE;
				end
			frame_pkg::PREAMBLE:
				if (p && d == code8b10b_pkg::K28_1) begin
					emit(d, 1'b0, e);
					pre_seen++;
					if (pre_seen == PREAMBLE_LEN)
						m_state = frame_pkg::BODY;
				end else if (p) begin
					m_state = frame_pkg::IDLE;
				end
			frame_pkg::BODY:
				if (p && !d[8]) begin
					emit(d, 1'b0, e);
					model_crc = crc_fold(model_crc, d[7:0]);
				end else if (p && d == code8b10b_pkg::K23_7) begin
					emit(d, 1'b0, e);
					trail_idx = 0;
					m_state = frame_pkg::TRAILER;
				end
			frame_pkg::TRAILER: begin
				emit({1'b0, 8'((model_crc ^ frame_pkg::CRC_XOR_OUT) >> (8 * trail_idx))}, 1'b0, e);
				trail_idx++;
				if (trail_idx == 4)
					m_state = frame_pkg::CLOSE;
			end
			default: begin
				emit(code8b10b_pkg::K28_5, 1'b0, e);
				m_state = frame_pkg::IDLE;
			end
		endcase
		exp_q.push_back(e);
	endtask

	task automatic send_packet();
		int n_bytes;
		int broken_at;
		n_bytes = $urandom_range(12, 0);
		// Roughly one packet in eight has a broken preamble
		broken_at = one_in(8) ? $urandom_range(PREAMBLE_LEN - 1, 1) : PREAMBLE_LEN;
		for (int i = 0; i < PREAMBLE_LEN; i++) begin
			if (i > 0 && one_in(5))
				step(1'b0, one_in(2), 9'($urandom));
			if (i == broken_at) begin
				step(1'b1, 1'b0, {1'b0, 8'($urandom)});
				return;
			end
			step(1'b1, i == 0, code8b10b_pkg::K28_1);
		end
		for (int i = 0; i < n_bytes; i++) begin
			if (one_in(5))
				step(1'b0, one_in(2), 9'($urandom));
			if (one_in(8))
				step(1'b1, 1'b0, IGNORED_K[$urandom_range(8, 0)]);
			step(1'b1, 1'b0, {1'b0, 8'($urandom)});
		end
		step(1'b1, 1'b0, code8b10b_pkg::K23_7);
		// Input pushed during the trailer is ignored
		repeat (5)
			step(one_in(2), one_in(2), 9'($urandom));
		repeat ($urandom_range(3, 0))
			step(1'b0, 1'b0, '0);
	endtask

	initial begin
		void'($urandom(32'h4b0d_c08b));
		clk = 1'b0;
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		model_rd = -1;
		line_rd = -1;
		m_state = frame_pkg::IDLE;
		repeat (16) @(negedge clk);
		check_value("pushout in reset", pushout, 0);
		check_value("startout in reset", startout, 0);
		check_value("dataout in reset", dataout, 0);
		reset = 1'b0;
		exp_q.push_back('0);
		// Pushes without startin open nothing
		repeat (6)
			step(one_in(2), 1'b0, 9'($urandom));
		for (int p = 0; p < N_PACKETS; p++)
			send_packet();
		repeat (3)
			step(1'b0, 1'b0, '0);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
code8b10b_pkg.sv
frame_pkg.sv
encoder_8b10b.sv
crc32_accumulator.sv
packet_framer.sv
line_encoder_top.sv
line_encoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the line encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f vlog.f --top-module line_encoder_tb \
	-o line_encoder_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/line_encoder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
